// ==== hw/gl_pkg.sv ====
// Graduation list backend package with sizes, latencies, opcodes and shared structs
package gl_pkg;

    localparam int unsigned NUM_ENTRIES = 16;                   // Usable capacity is one less
    localparam int unsigned GL_IDX_W    = $clog2(NUM_ENTRIES);
    localparam int unsigned GL_CNT_W    = GL_IDX_W + 1;         // Occupancy needs one extra bit
    localparam int unsigned NUM_LANES   = 2;
    localparam int unsigned DATA_W      = 32;
    localparam int unsigned REG_W       = 5;
    localparam int unsigned LAT_W       = 3;                    // Wide enough for the longest op

    typedef logic [GL_IDX_W-1:0] gl_index_t;
    typedef logic [GL_CNT_W-1:0] gl_count_t;
    typedef logic [LAT_W-1:0]    lat_t;

    // Lane busy cycles per opcode
    localparam lat_t LAT_ADD     = lat_t'(1);
    localparam lat_t LAT_SUB     = lat_t'(2);
    localparam lat_t LAT_XOR     = lat_t'(4);
    localparam lat_t LAT_ILLEGAL = lat_t'(1);

    localparam gl_count_t GL_CAPACITY = gl_count_t'(NUM_ENTRIES - 1);

    typedef enum logic [2:0] {
        OP_ADD     = 3'd0,
        OP_SUB     = 3'd1,
        OP_XOR     = 3'd2,
        OP_STORE   = 3'd3,
        OP_ILLEGAL = 3'd7
    } op_t;

    // Incoming instruction, operands carried as immediates
    typedef struct packed {
        logic              valid;
        op_t               op;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] operand_a;
        logic [DATA_W-1:0] operand_b;
    } instr_t;

    // One slot of the graduation list
    typedef struct packed {
        op_t               op;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] result;
        logic              exception;
    } gl_entry_t;

    typedef struct packed {
        logic              valid;
        op_t               op;
        gl_index_t         gl_index;
        logic [DATA_W-1:0] operand_a;
        logic [DATA_W-1:0] operand_b;
    } lane_req_t;

    typedef struct packed {
        logic              valid;
        gl_index_t         gl_index;
        logic [DATA_W-1:0] result;
        logic              exception;
    } writeback_t;

    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] result;
        logic              exception;
    } commit_t;

endpackage

// ==== hw/dispatch_unit.sv ====
// Dispatch unit that accepts instructions, allocates list entries and steers ops to a free lane
module dispatch_unit (
    input  logic                                      clk_i,
    input  logic                                      rstn_i,
    input  gl_pkg::instr_t                            instr_i,
    input  logic              [gl_pkg::NUM_LANES-1:0] lane_busy_i,
    input  logic                                      gl_full_i,
    input  gl_pkg::gl_index_t                         tail_index_i,
    input  logic                                      flush_i,
    output gl_pkg::instr_t                            alloc_o,
    output gl_pkg::lane_req_t [gl_pkg::NUM_LANES-1:0] lane_req_o,
    output logic                                      stall_o
);

    logic                         is_store;
    logic                         lane_free_any;
    logic [gl_pkg::NUM_LANES-1:0] lane_sel;    // One-hot, lowest free lane
    logic                         found;
    logic                         accept;
    logic                         recover_q;   // Flush seen last cycle

    assign is_store      = (instr_i.op == gl_pkg::OP_STORE);
    assign lane_free_any = |(~lane_busy_i);

    // Priority encoder over the free lanes
    always_comb begin
        lane_sel = '0;
        found    = 1'b0;
        for (int i = 0; i < gl_pkg::NUM_LANES; i++) begin
            if (!lane_busy_i[i] && !found) begin
                lane_sel[i] = 1'b1;
                found       = 1'b1;
            end
        end
    end

    // Hold input while the list and lanes recover from a flush
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            recover_q <= 1'b0;
        end else begin
            recover_q <= flush_i;
        end
    end

    assign stall_o = gl_full_i | flush_i | recover_q
                   | (instr_i.valid & ~is_store & ~lane_free_any);
    assign accept  = instr_i.valid & ~stall_o;

    always_comb begin
        alloc_o       = instr_i;
        alloc_o.valid = accept;
        for (int i = 0; i < gl_pkg::NUM_LANES; i++) begin
            lane_req_o[i].valid     = accept & ~is_store & lane_sel[i]; // Stores skip the lanes
            lane_req_o[i].op        = instr_i.op;
            lane_req_o[i].gl_index  = tail_index_i;
            lane_req_o[i].operand_a = instr_i.operand_a;
            lane_req_o[i].operand_b = instr_i.operand_b;
        end
    end

endmodule

// ==== hw/exec_lane.sv ====
// Execution lane that runs one multi-cycle ALU op and writes the result back to the list
module exec_lane (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               flush_i,
    input  gl_pkg::lane_req_t  req_i,
    output logic               busy_o,
    output gl_pkg::writeback_t wb_o
);

    gl_pkg::lat_t              count_q;     // Cycles left, 1 means writeback now
    gl_pkg::lat_t              lat_d;
    gl_pkg::gl_index_t         index_q;
    logic [gl_pkg::DATA_W-1:0] result_d;
    logic [gl_pkg::DATA_W-1:0] result_q;
    logic                      exc_d;
    logic                      exc_q;

    always_comb begin
        result_d = '0;
        exc_d    = 1'b0;
        lat_d    = gl_pkg::LAT_ILLEGAL;
        case (req_i.op)
            gl_pkg::OP_ADD: begin
                result_d = req_i.operand_a + req_i.operand_b;
                lat_d    = gl_pkg::LAT_ADD;
            end
            gl_pkg::OP_SUB: begin
                result_d = req_i.operand_a - req_i.operand_b;
                lat_d    = gl_pkg::LAT_SUB;
            end
            gl_pkg::OP_XOR: begin
                result_d = req_i.operand_a ^ req_i.operand_b;
                lat_d    = gl_pkg::LAT_XOR;
            end
            default: exc_d = 1'b1;  // Illegal opcode, result stays zero
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            count_q <= '0;
        end else if (flush_i) begin
            count_q <= '0;                      // Drop in-flight work
        end else if (req_i.valid) begin
            count_q <= lat_d;
        end else if (count_q != '0) begin
            count_q <= count_q - gl_pkg::lat_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            index_q  <= req_i.gl_index;
            result_q <= result_d;
            exc_q    <= exc_d;
        end
    end

    // Free again in the writeback cycle so a new op can follow back to back
    assign busy_o = (count_q > gl_pkg::lat_t'(1));

    always_comb begin
        wb_o.valid     = (count_q == gl_pkg::lat_t'(1)) & ~flush_i;
        wb_o.gl_index  = index_q;
        wb_o.result    = result_q;
        wb_o.exception = exc_q;
    end

endmodule

// ==== hw/graduation_list.sv ====
// Graduation list, a circular reorder buffer with lane writebacks and in-order dual head read
module graduation_list (
    input  logic                                       clk_i,
    input  logic                                       rstn_i,
    input  gl_pkg::instr_t                             alloc_i,
    input  gl_pkg::writeback_t [gl_pkg::NUM_LANES-1:0] wb_i,
    input  logic               [1:0]                   read_head_i,
    input  logic                                       flush_commit_i,
    output gl_pkg::gl_index_t                          assigned_index_o,
    output gl_pkg::gl_entry_t  [1:0]                   head_entry_o,
    output logic               [1:0]                   head_finished_o,
    output logic                                       full_o,
    output logic                                       empty_o
);

    gl_pkg::gl_entry_t entries [gl_pkg::NUM_ENTRIES];
    logic [gl_pkg::NUM_ENTRIES-1:0] finished_q;

    gl_pkg::gl_index_t head_q;
    gl_pkg::gl_index_t tail_q;
    gl_pkg::gl_index_t head_next;      // Second oldest slot
    gl_pkg::gl_count_t count_q;
    gl_pkg::gl_count_t pop_cnt;
    gl_pkg::gl_count_t push_cnt;
    gl_pkg::gl_entry_t new_entry;

    logic write_en;
    logic is_store;

    assign is_store = (alloc_i.op == gl_pkg::OP_STORE);
    assign write_en = alloc_i.valid & ~full_o & ~flush_commit_i;

    assign push_cnt  = gl_pkg::gl_count_t'(write_en);
    assign pop_cnt   = gl_pkg::gl_count_t'(read_head_i[0]) + gl_pkg::gl_count_t'(read_head_i[1]);
    assign head_next = head_q + gl_pkg::gl_index_t'(1);

    // A store carries its data in operand_b and is complete on insertion
    always_comb begin
        new_entry.op        = alloc_i.op;
        new_entry.rd        = alloc_i.rd;
        new_entry.result    = is_store ? alloc_i.operand_b : '0;
        new_entry.exception = 1'b0;
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries[tail_q] <= new_entry;
        end
        for (int i = 0; i < gl_pkg::NUM_LANES; i++) begin
            if (wb_i[i].valid) begin
                entries[wb_i[i].gl_index].result    <= wb_i[i].result;
                entries[wb_i[i].gl_index].exception <= wb_i[i].exception;
            end
        end
    end

    // Finished bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            finished_q <= '0;
        end else begin
            if (write_en) begin
                finished_q[tail_q] <= is_store;
            end
            for (int i = 0; i < gl_pkg::NUM_LANES; i++) begin
                if (wb_i[i].valid) begin
                    finished_q[wb_i[i].gl_index] <= 1'b1;
                end
            end
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_commit_i) begin
            head_q  <= '0;         // Full flush empties the list
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            head_q  <= head_q + gl_pkg::gl_index_t'(pop_cnt);
            tail_q  <= tail_q + gl_pkg::gl_index_t'(write_en);
            count_q <= count_q + push_cnt - pop_cnt;
        end
    end

    // Occupied and finished, oldest first
    assign head_finished_o[0] = (count_q != '0) & finished_q[head_q];
    assign head_finished_o[1] = (count_q > gl_pkg::gl_count_t'(1)) & finished_q[head_next];

    assign head_entry_o[0] = entries[head_q];
    assign head_entry_o[1] = entries[head_next];

    assign assigned_index_o = tail_q;
    assign full_o           = (count_q == gl_pkg::GL_CAPACITY);
    assign empty_o          = (count_q == '0);

endmodule

// ==== hw/commit_unit.sv ====
// Commit unit that retires finished head entries in order and turns an exception into a flush
module commit_unit (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  gl_pkg::gl_entry_t [1:0]      head_entry_i,
    input  logic              [1:0]      head_finished_i,
    output logic              [1:0]      read_head_o,
    output gl_pkg::commit_t   [1:0]      commit_o,
    output logic                         exception_o,
    output logic                         flush_o
);

    logic any_exc;   // Either head entry excepted

    assign any_exc = head_entry_i[0].exception | head_entry_i[1].exception;

    // Nothing retires while the flush is being applied
    assign read_head_o[0] = head_finished_i[0] & ~flush_o;
    // Second slot only behind a clean first slot
    assign read_head_o[1] = read_head_o[0] & head_finished_i[1] & ~any_exc;

    assign exception_o = read_head_o[0] & head_entry_i[0].exception;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            flush_o <= 1'b0;
        end else begin
            flush_o <= exception_o;   // Single cycle, commits are blocked meanwhile
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            commit_o[i].valid     = read_head_o[i];
            commit_o[i].rd        = head_entry_i[i].rd;
            commit_o[i].result    = head_entry_i[i].result;
            commit_o[i].exception = head_entry_i[i].exception;
        end
    end

endmodule

// ==== hw/gl_backend_top.sv ====
// Backend top joining dispatch, the execution lanes, the graduation list and commit
module gl_backend_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  gl_pkg::instr_t          instr_i,
    output logic                    stall_o,
    output gl_pkg::commit_t [1:0]   commit_o,
    output logic                    exception_o,
    output logic                    empty_o,
    output logic                    full_o
);

    logic               [gl_pkg::NUM_LANES-1:0] lane_busy;
    gl_pkg::lane_req_t  [gl_pkg::NUM_LANES-1:0] lane_req;
    gl_pkg::writeback_t [gl_pkg::NUM_LANES-1:0] lane_wb;
    gl_pkg::instr_t                             alloc;
    gl_pkg::gl_index_t                          tail_index;
    gl_pkg::gl_entry_t  [1:0]                   head_entry;
    logic               [1:0]                   head_finished;
    logic               [1:0]                   read_head;
    logic                                       flush;

    dispatch_unit dispatch_unit_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .instr_i      (instr_i),
        .lane_busy_i  (lane_busy),
        .gl_full_i    (full_o),
        .tail_index_i (tail_index),
        .flush_i      (flush),
        .alloc_o      (alloc),
        .lane_req_o   (lane_req),
        .stall_o      (stall_o)
    );

    for (genvar i = 0; i < gl_pkg::NUM_LANES; i++) begin : g_lane
        exec_lane exec_lane_inst (
            .clk_i   (clk_i),
            .rstn_i  (rstn_i),
            .flush_i (flush),
            .req_i   (lane_req[i]),
            .busy_o  (lane_busy[i]),
            .wb_o    (lane_wb[i])
        );
    end

    graduation_list graduation_list_inst (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .alloc_i          (alloc),
        .wb_i             (lane_wb),
        .read_head_i      (read_head),
        .flush_commit_i   (flush),
        .assigned_index_o (tail_index),
        .head_entry_o     (head_entry),
        .head_finished_o  (head_finished),
        .full_o           (full_o),
        .empty_o          (empty_o)
    );

    commit_unit commit_unit_inst (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .head_entry_i    (head_entry),
        .head_finished_i (head_finished),
        .read_head_o     (read_head),
        .commit_o        (commit_o),
        .exception_o     (exception_o),
        .flush_o         (flush)
    );

endmodule

// ==== tests/gl_properties.sv ====
// Bound checks on graduation list occupancy, status flags and the head read mask
module gl_properties (
    input logic              clk_i,
    input logic              rstn_i,
    input gl_pkg::gl_count_t count_i,
    input logic              full_i,
    input logic              empty_i,
    input logic [1:0]        read_head_i
);

    count_bound_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_i <= gl_pkg::GL_CAPACITY)
        else $error("Graduation list count above capacity");

    full_empty_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(full_i && empty_i))
        else $error("Graduation list full and empty at once");

    // Slot 1 never retires ahead of slot 0
    read_order_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        read_head_i != 2'b10)
        else $error("Head read mask retires slot 1 alone");

endmodule

bind graduation_list gl_properties gl_properties_inst (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .count_i     (count_q),
    .full_i      (full_o),
    .empty_i     (empty_o),
    .read_head_i (read_head_i)
);

// ==== tests/tb_gl_backend.sv ====
// Testbench for the graduation list backend, replays the stimulus file and checks the commit stream
module tb_gl_backend;

    localparam int unsigned NUM_FIELDS = 7;      // Words per stimulus line
    localparam int unsigned MAX_LINES  = 64;
    localparam int unsigned CLK_PERIOD = 40;
    localparam logic [31:0] END_MARK   = 32'hff;

    typedef struct packed {
        logic [gl_pkg::REG_W-1:0]  rd;
        logic [gl_pkg::DATA_W-1:0] result;
        logic                      exception;
        logic                      restart;
    } expect_t;

    logic                  clk_i;
    logic                  rstn_i;
    gl_pkg::instr_t        instr_i;
    logic                  stall_o;
    gl_pkg::commit_t [1:0] commit_o;
    logic                  exception_o;
    logic                  empty_o;
    logic                  full_o;

    logic [31:0] stim_mem [MAX_LINES*NUM_FIELDS];
    expect_t     exp_q [$];                      // Commits still to come, oldest first
    int unsigned num_lines;
    int unsigned idx;
    int unsigned cycle_cnt;
    int unsigned cycle_limit;
    logic        seen_stall;
    int unsigned occupancy;                      // Entries the list should hold this cycle
    logic        flush_next;                     // Exception last cycle, list clears now

    gl_backend_top gl_backend_top_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .instr_i     (instr_i),
        .stall_o     (stall_o),
        .commit_o    (commit_o),
        .exception_o (exception_o),
        .empty_o     (empty_o),
        .full_o      (full_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    task automatic fail_run(input string reason);
        $display("Error at time %0t: %s", $time, reason);
        $display("Result: FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Wrong value on %s", what);
        end
    endtask

    function automatic gl_pkg::instr_t line_instr(input int unsigned line);
        gl_pkg::instr_t ins;
        int unsigned    base;
        base          = line * NUM_FIELDS;
        ins.valid     = 1'b1;
        ins.op        = gl_pkg::op_t'(stim_mem[base][2:0]);
        ins.rd        = stim_mem[base+1][gl_pkg::REG_W-1:0];
        ins.operand_a = stim_mem[base+2];
        ins.operand_b = stim_mem[base+3];
        return ins;
    endfunction

    function automatic expect_t line_expect(input int unsigned line);
        expect_t     e;
        int unsigned base;
        base        = line * NUM_FIELDS;
        e.rd        = stim_mem[base+1][gl_pkg::REG_W-1:0];
        e.result    = stim_mem[base+4];
        e.exception = stim_mem[base+5][0];
        e.restart   = stim_mem[base+6][0];
        return e;
    endfunction

    // First line at or after the given one that resumes after a flush
    function automatic int unsigned next_restart(input int unsigned line);
        int unsigned j;
        j = line;
        while (j < num_lines && !stim_mem[j*NUM_FIELDS+6][0]) begin
            j++;
        end
        return j;
    endfunction

    task automatic check_commit(input int slot);
        expect_t e;
        if (exp_q.size() == 0) begin
            fail_run("a commit appeared with no instruction left to retire");
        end else begin
            e = exp_q.pop_front();
            check_value("commit rd", commit_o[slot].rd, e.rd);
            check_value("commit result", commit_o[slot].result, e.result);
            check_value("commit exception", commit_o[slot].exception, e.exception);
            if (slot == 0) begin
                check_value("exception_o", exception_o, e.exception);
            end
            if (e.exception) begin
                // Younger lines were flushed and never retire
                while (exp_q.size() != 0 && !exp_q[0].restart) begin
                    void'(exp_q.pop_front());
                end
            end
        end
    endtask

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            fail_run("timeout, the commit stream did not finish in time");
        end
    end

    // Outputs are sampled mid cycle where they are stable
    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (stall_o) seen_stall = 1'b1;
            check_value("full_o", full_o, occupancy == gl_pkg::NUM_ENTRIES - 1);
            check_value("empty_o", empty_o, occupancy == 0);
            for (int s = 0; s < 2; s++) begin
                if (commit_o[s].valid) check_commit(s);
            end
            if (flush_next) begin
                occupancy = 0;                   // Full flush empties the list
            end else begin
                occupancy = occupancy + (instr_i.valid && !stall_o)
                          - commit_o[0].valid - commit_o[1].valid;
            end
            flush_next = exception_o;
        end
    end

    initial begin
        rstn_i      = 1'b0;
        instr_i     = '0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        seen_stall  = 1'b0;
        occupancy   = 0;
        flush_next  = 1'b0;
        num_lines   = 0;
        $readmemh("tests/gl_stimulus.txt", stim_mem);
        while (num_lines < MAX_LINES && stim_mem[num_lines*NUM_FIELDS] != END_MARK) begin
            exp_q.push_back(line_expect(num_lines));
            num_lines++;
        end
        cycle_limit = 40 * num_lines + 100;

        repeat (2) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;

        idx = 0;
        while (idx < num_lines) begin
            instr_i = line_instr(idx);
            @(negedge clk_i);
            if (exception_o) begin
                idx = next_restart(idx);   // Current and older young lines are dropped
            end else if (!stall_o) begin
                idx++;
            end
            @(posedge clk_i);
            #2;
        end
        instr_i = '0;

        while (exp_q.size() != 0) @(posedge clk_i);
        @(negedge clk_i);
        check_value("empty_o at end", empty_o, 1);
        check_value("stall_o raised during run", seen_stall, 1);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== tests/gl_stimulus.txt ====
// Columns: opcode rd operand_a operand_b expected_result expected_exception restart
// Opcodes 0 add, 1 sub, 2 xor, 3 store, 7 illegal; opcode ff ends the list
3 01 00000000 0000aaaa 0000aaaa 0 0
3 02 00000000 12345678 12345678 0 0
3 03 00000000 deadbeef deadbeef 0 0
2 04 f0f0f0f0 0ff00ff0 ff00ff00 0 0
0 05 00000005 00000007 0000000c 0 0
1 06 00000010 00000003 0000000d 0 0
0 07 ffffffff 00000001 00000000 0 0
2 08 11111111 22222222 33333333 0 0
2 09 aaaaaaaa 55555555 ffffffff 0 0
2 0a 0000ffff 00ff00ff 00ffff00 0 0
2 0b 12345678 87654321 95511559 0 0
2 0c 00000000 0000000f 0000000f 0 0
3 0d 00000000 00000001 00000001 0 0
3 0e 00000000 00000002 00000002 0 0
3 0f 00000000 00000003 00000003 0 0
3 10 00000000 00000004 00000004 0 0
7 11 00000001 00000002 00000000 1 0
3 12 00000000 0badf00d 0badf00d 0 0
3 13 00000000 0badf00e 0badf00e 0 0
3 14 00000000 0badf00f 0badf00f 0 0
0 15 00000003 00000004 00000007 0 1
3 16 00000000 cafef00d cafef00d 0 0
ff 00 00000000 00000000 00000000 0 0

// ==== src.f ====
hw/gl_pkg.sv
hw/dispatch_unit.sv
hw/exec_lane.sv
hw/graduation_list.sv
hw/commit_unit.sv
hw/gl_backend_top.sv
tests/gl_properties.sv
tests/tb_gl_backend.sv

// ==== Bender.yml ====
package:
  name: gl_backend

sources:
  - files:
      - hw/gl_pkg.sv
      - hw/dispatch_unit.sv
      - hw/exec_lane.sv
      - hw/graduation_list.sv
      - hw/commit_unit.sv
      - hw/gl_backend_top.sv
  - target: test
    files:
      - tests/gl_properties.sv
      - tests/tb_gl_backend.sv
